// ==== sim.f ====
+incdir+test
rtl/apu_reg_pkg.sv
rtl/apu_voice_pkg.sv
rtl/apu_regs.sv
rtl/frame_seq.sv
rtl/pulse_voice.sv
rtl/apu_mixer.sv
rtl/apu_top.sv
test/tb_apu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator and run; the exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_apu -f sim.f \
  && ./obj_dir/Vtb_apu \
  || exit 1

// ==== test/tb_apu_tasks.svh ====
`ifndef TB_APU_TASKS_SVH
`define TB_APU_TASKS_SVH

  // ---------------------------------------------------------------------
  // checking
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_out(input string name, input out_t got, input out_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  // written value after write mask, then read mask
  function automatic byte_t expect_readback(input addr_t addr, input byte_t data);
    byte_t wm;
    byte_t rm;
    wm = 8'h00;
    rm = 8'h00;
    case (addr)
      addr_nr11, addr_nr21: rm = 8'h3F;
      addr_nr13, addr_nr23: rm = 8'hFF;
      addr_nr14, addr_nr24: begin
        wm = 8'h38;
        rm = 8'hBF;
      end
      default: ;
    endcase
    return (data | wm) | rm;
  endfunction

  // ---------------------------------------------------------------------
  // cpu bus
  task automatic bus_write(input addr_t addr, input byte_t data);
    @(posedge clk);
    #1;
    bus.addr  = addr;
    bus.data  = data;
    bus.write = 1'b1;
    @(posedge clk);
    #1;
    bus.write = 1'b0;
  endtask

  task automatic bus_read(input addr_t addr, output byte_t data, output logic oe);
    @(posedge clk);
    #1;
    bus.addr = addr;
    bus.read = 1'b1;
    @(posedge clk);
    #1;
    data     = bus_out;
    oe       = bus_oe;
    bus.read = 1'b0;
  endtask

  task automatic read_expect(input string name, input addr_t addr, input byte_t exp);
    byte_t data;
    logic  oe;
    bus_read(addr, data, oe);
    check_bit($sformatf("%s bus_oe", name), oe, 1'b1);
    check_byte(name, data, exp);
  endtask

  // one side follows voice 1 between 0 and full while the other stays silent
  task automatic watch_pan(input logic left, input out_t full);
    out_t loud;
    out_t quiet;
    int   seen;
    int   i;
    seen = -1;
    for (i = 0; i < 4 * duty_window; i++) begin
      @(posedge clk);
      #1;
      loud  = left ? out_l : out_r;
      quiet = left ? out_r : out_l;
      check_out(left ? "out_r" : "out_l", quiet, '0);
      if (loud !== '0) begin
        check_out(left ? "out_l" : "out_r", loud, full);
        if (seen < 0) begin
          seen = i;
        end
      end
    end
    if ((seen < 0) || (seen >= duty_window)) begin
      abort_run("output never reached the full level within one duty period");
    end
  endtask

  // ---------------------------------------------------------------------
  // directed tests
  task automatic readback_regs();
    addr_t regs [10];
    addr_t holes [4];
    byte_t data;
    logic  oe;
    regs  = '{addr_nr11, addr_nr12, addr_nr13, addr_nr14, addr_nr21,
              addr_nr22, addr_nr23, addr_nr24, addr_nr50, addr_nr51};
    // wave, noise and wave ram slots are gone
    holes = '{16'hFF1A, 16'hFF20, 16'hFF30, 16'h0000};
    foreach (regs[i]) begin
      data = byte_t'($random(seed));
      bus_write(regs[i], data);
      read_expect($sformatf("reg %h", regs[i]), regs[i], expect_readback(regs[i], data));
    end
    read_expect("nr10", addr_nr10, 8'hFF);
    read_expect("nr20", addr_nr20, 8'hFF);
    foreach (holes[i]) begin
      bus_read(holes[i], data, oe);
      check_bit("bus_oe", oe, 1'b0);
      check_byte("bus_out", data, 8'h00);
    end
  endtask

  task automatic power_off_lock();
    byte_t data;
    data = byte_t'($random(seed));
    if (data == rst_nr50) begin
      data = ~data;
    end
    bus_write(addr_nr52, 8'h00);
    read_expect("nr52", addr_nr52, 8'h70);
    bus_write(addr_nr50, data);
    read_expect("nr50", addr_nr50, rst_nr50);
    repeat (64) begin
      @(posedge clk);
      #1;
      check_out("out_r", out_r, '0);
      check_out("out_l", out_l, '0);
    end
    bus_write(addr_nr52, 8'h80);
    read_expect("nr52", addr_nr52, 8'hF0);
    bus_write(addr_nr50, data);
    read_expect("nr50", addr_nr50, data);
  endtask

  task automatic trigger_status();
    bus_write(addr_nr12, 8'hF0);
    bus_write(addr_nr14, 8'h80);
    read_expect("nr52", addr_nr52, 8'hF1);
    // dac off so the trigger must not enable
    bus_write(addr_nr12, 8'h00);
    bus_write(addr_nr14, 8'h80);
    read_expect("nr52", addr_nr52, 8'hF0);
    bus_write(addr_nr22, 8'hF0);
    bus_write(addr_nr24, 8'h80);
    read_expect("nr52", addr_nr52, 8'hF2);
    bus_write(addr_nr22, 8'h00);
    bus_write(addr_nr24, 8'h80);
    read_expect("nr52", addr_nr52, 8'hF0);
  endtask

  task automatic length_expiry();
    byte_t data;
    logic  oe;
    int    start;
    // length_load 63 leaves a single tick
    bus_write(addr_nr11, 8'hBF);
    bus_write(addr_nr12, 8'hF0);
    bus_write(addr_nr14, 8'hC0);
    start = cyc;
    read_expect("nr52", addr_nr52, 8'hF1);
    data = 8'hF1;
    while (data[0]) begin
      bus_read(addr_nr52, data, oe);
      if (data[0] && (cyc - start > len_limit)) begin
        abort_run("length counter did not expire within 4096 steps");
      end
    end
    check_byte("nr52", data, 8'hF0);
  endtask

  task automatic mix_levels();
    vol_t vol;
    out_t full;
    vol = vol_t'($random(seed));
    if (vol == '0) begin
      vol = 4'd9;
    end
    // master volume 3 scales by 3 + 1
    full = out_t'(vol) * out_t'(4);
    bus_write(addr_nr51, 8'h10);
    bus_write(addr_nr50, 8'h30);
    bus_write(addr_nr11, 8'hC0);
    bus_write(addr_nr12, {vol, 4'h0});
    bus_write(addr_nr13, 8'hFF);
    bus_write(addr_nr14, 8'h87);
    watch_pan(1'b1, full);
    bus_write(addr_nr51, 8'h01);
    bus_write(addr_nr50, 8'h03);
    repeat (2 * step_cycles) @(posedge clk);
    watch_pan(1'b0, full);
  endtask

  task automatic envelope_decay();
    out_t peak;
    out_t last;
    int   w;
    // decreasing from F with period 1
    bus_write(addr_nr12, 8'hF1);
    bus_write(addr_nr14, 8'h87);
    repeat (duty_window) @(posedge clk);
    last = '0;
    for (w = 0; w < 3; w++) begin
      peak = '0;
      repeat (env_window) begin
        @(posedge clk);
        #1;
        if (out_r > peak) begin
          peak = out_r;
        end
      end
      if ((w > 0) && (peak >= last)) begin
        abort_run($sformatf("envelope did not decay, window %0d peak %h after %h",
                            w, peak, last));
      end
      last = peak;
    end
  endtask

`endif

// ==== test/tb_apu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_apu;
  import apu_reg_pkg::*;
  import apu_voice_pkg::*;

  localparam int clk_period  = 8;
  localparam int step_cycles = 4;
  // one length tick per 4096 steps
  localparam int len_limit   = 4096 * step_cycles + 4;
  localparam int duty_window = 8 * step_cycles * 2;
  // envelope ticks come 16384 steps apart
  localparam int env_window  = 16384 * step_cycles;
  localparam int bus_cycles  = 600;
  localparam int total_cycles = 10 + bus_cycles + len_limit + 9 * duty_window
                                + 3 * env_window;

  logic       clk;
  logic       rst;
  logic [1:0] tphase;
  bus_req_t   bus;
  byte_t      bus_out;
  logic       bus_oe;
  out_t       out_r;
  out_t       out_l;
  integer     seed;
  int         cyc;

  apu_top u_apu_top (
    .clk     (clk),
    .rst     (rst),
    .tphase  (tphase),
    .bus     (bus),
    .bus_out (bus_out),
    .bus_oe  (bus_oe),
    .out_r   (out_r),
    .out_l   (out_l)
  );

  `include "tb_apu_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // cpu phase runs free just off the clock edge
  always @(posedge clk) begin
    #1;
    tphase <= tphase + 2'd1;
  end

  // ---------------------------------------------------------------------
  // test sequence
  initial begin
    seed   = 90;
    cyc    = 0;
    rst    = 1'b1;
    tphase = 2'd0;
    bus    = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    readback_regs();
    power_off_lock();
    trigger_status();
    length_expiry();
    mix_levels();
    envelope_decay();

    $display("all tests passed");
    $finish;
  end

  initial begin
    #(total_cycles * 2 * clk_period);
    abort_run("watchdog expired before the test sequence finished");
  end

endmodule

`default_nettype wire

// ==== rtl/apu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module apu_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [1:0]            tphase,
  input  apu_reg_pkg::bus_req_t bus,
  output apu_reg_pkg::byte_t    bus_out,
  output logic                  bus_oe,
  output apu_voice_pkg::out_t   out_r,
  output apu_voice_pkg::out_t   out_l
);
  import apu_voice_pkg::*;

  pulse_cfg_t cfg1;
  pulse_cfg_t cfg2;
  mix_cfg_t   mix;
  seq_ticks_t ticks;
  sample_t    s1;
  sample_t    s2;
  logic       en1;
  logic       en2;
  logic       power_on;
  logic       trig1;
  logic       trig2;
  logic       power_clr;

  apu_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus),
    .en1       (en1),
    .en2       (en2),
    .bus_out   (bus_out),
    .bus_oe    (bus_oe),
    .cfg1      (cfg1),
    .cfg2      (cfg2),
    .mix       (mix),
    .power_on  (power_on),
    .trig1     (trig1),
    .trig2     (trig2),
    .power_clr (power_clr)
  );

  frame_seq u_seq (
    .clk      (clk),
    .rst      (rst),
    .tphase   (tphase),
    .power_on (power_on),
    .ticks    (ticks)
  );

  pulse_voice u_voice1 (
    .clk    (clk),
    .rst    (rst),
    .cfg    (cfg1),
    .trig   (trig1),
    .clr    (power_clr),
    .ticks  (ticks),
    .sample (s1),
    .en     (en1)
  );

  pulse_voice u_voice2 (
    .clk    (clk),
    .rst    (rst),
    .cfg    (cfg2),
    .trig   (trig2),
    .clr    (power_clr),
    .ticks  (ticks),
    .sample (s2),
    .en     (en2)
  );

  apu_mixer u_mixer (
    .clk      (clk),
    .rst      (rst),
    .power_on (power_on),
    .mix      (mix),
    .step     (ticks.step),
    .s1       (s1),
    .s2       (s2),
    .out_r    (out_r),
    .out_l    (out_l)
  );

endmodule

`default_nettype wire

// ==== rtl/apu_mixer.sv ====
`timescale 1ns/1ns
`default_nettype none

module apu_mixer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    power_on,
  input  apu_voice_pkg::mix_cfg_t mix,
  input  logic                    step,
  input  apu_voice_pkg::sample_t  s1,
  input  apu_voice_pkg::sample_t  s2,
  output apu_voice_pkg::out_t     out_r,
  output apu_voice_pkg::out_t     out_l
);
  import apu_voice_pkg::*;

  out_t sum_r;
  out_t sum_l;
  out_t gain_r;
  out_t gain_l;

  // pan bits 0/1 right, 4/5 left
  always_comb begin
    sum_r = '0;
    sum_l = '0;
    if (mix.pan[0]) sum_r = sum_r + out_t'(s1);
    if (mix.pan[1]) sum_r = sum_r + out_t'(s2);
    if (mix.pan[4]) sum_l = sum_l + out_t'(s1);
    if (mix.pan[5]) sum_l = sum_l + out_t'(s2);
    gain_r = out_t'(mix.vol_r) + 9'd1;
    gain_l = out_t'(mix.vol_l) + 9'd1;
  end

  // max 30 * 8 = 240, fits in 9 bits
  always_ff @(posedge clk) begin
    if (rst || !power_on) begin
      out_r <= '0;
      out_l <= '0;
    end else if (step) begin
      out_r <= sum_r * gain_r;
      out_l <= sum_l * gain_l;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pulse_voice.sv ====
`timescale 1ns/1ns
`default_nettype none

module pulse_voice (
  input  logic                      clk,
  input  logic                      rst,
  input  apu_voice_pkg::pulse_cfg_t cfg,
  input  logic                      trig,
  input  logic                      clr,
  input  apu_voice_pkg::seq_ticks_t ticks,
  output apu_voice_pkg::sample_t    sample,
  output logic                      en
);
  import apu_voice_pkg::*;

  freq_t      timer;
  logic [2:0] phase;
  len_t       len_cnt;
  len_t       len_next;
  vol_t       env_cnt;
  logic [2:0] env_clk;
  vol_t       volume;
  logic [2:0] duty_th;

  always_comb begin
    len_next = (len_cnt != '0) ? len_cnt - len_t'(1) : '0;
    // counter runs upward and the direction flips it into volume
    volume   = cfg.env_dir ? env_cnt : (vol_max ^ env_cnt);
    case (cfg.duty)
      2'd0:    duty_th = 3'd1;
      2'd1:    duty_th = 3'd2;
      2'd2:    duty_th = 3'd4;
      default: duty_th = 3'd6;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || clr) begin
      en      <= 1'b0;
      timer   <= freq_max;
      phase   <= '0;
      len_cnt <= '0;
      env_cnt <= '0;
      env_clk <= '0;
      sample  <= '0;
    end else if (trig) begin
      // dac off when NRx2 bits 7..3 are all clear
      en      <= ({cfg.env_start, cfg.env_dir} != 5'd0);
      timer   <= freq_max ^ cfg.freq;
      phase   <= '0;
      len_cnt <= len_full - len_t'(cfg.length_load);
      env_cnt <= cfg.env_dir ? cfg.env_start : (vol_max ^ cfg.env_start);
      env_clk <= cfg.env_period;
    end else if (ticks.step) begin
      // -----------------------------------------------------------------
      // frequency timer
      if (timer == '0) begin
        timer <= freq_max ^ cfg.freq;
        phase <= phase + 3'd1;
      end else begin
        timer <= timer - freq_t'(1);
      end

      // length counter
      if (ticks.length && cfg.length_en) begin
        len_cnt <= len_next;
        if (len_next == '0) begin
          en <= 1'b0;
        end
      end

      // envelope is frozen by period 0
      if (ticks.env && (cfg.env_period != 3'd0)) begin
        if (env_clk > 3'd1) begin
          env_clk <= env_clk - 3'd1;
        end else begin
          env_clk <= cfg.env_period;
          if (env_cnt < vol_max) begin
            env_cnt <= env_cnt + vol_t'(1);
          end
        end
      end

      sample <= (en && (phase < duty_th)) ? volume : '0;
    end
  end

  clr_kills_voice: assert property (@(posedge clk) disable iff (rst) clr |=> !en);

endmodule

`default_nettype wire

// ==== rtl/frame_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_seq (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [1:0]                tphase,
  input  logic                      power_on,
  output apu_voice_pkg::seq_ticks_t ticks
);
  import apu_voice_pkg::*;

  logic [13:0] cnt;
  logic [13:0] cnt_next;

  assign cnt_next = cnt + 14'd1;

  // length every 4096 steps, envelope once per wrap
  always_comb begin
    ticks.step   = power_on && (tphase == step_phase);
    ticks.length = ticks.step && (cnt_next[11:0] == 12'd0);
    ticks.env    = ticks.step && (cnt_next == 14'b11_1000_0000_0000);
  end

  always_ff @(posedge clk) begin
    if (rst || !power_on) begin
      cnt <= '0;
    end else if (ticks.step) begin
      cnt <= cnt_next;
    end
  end

  ticks_on_step: assert property (@(posedge clk) disable iff (rst)
    (ticks.length || ticks.env) |-> ticks.step);

endmodule

`default_nettype wire

// ==== rtl/apu_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module apu_regs (
  input  logic                      clk,
  input  logic                      rst,
  input  apu_reg_pkg::bus_req_t     bus,
  input  logic                      en1,
  input  logic                      en2,
  output apu_reg_pkg::byte_t        bus_out,
  output logic                      bus_oe,
  output apu_voice_pkg::pulse_cfg_t cfg1,
  output apu_voice_pkg::pulse_cfg_t cfg2,
  output apu_voice_pkg::mix_cfg_t   mix,
  output logic                      power_on,
  output logic                      trig1,
  output logic                      trig2,
  output logic                      power_clr
);
  import apu_reg_pkg::*;

  byte_t nr11, nr12, nr13, nr14;
  byte_t nr21, nr22, nr23, nr24;
  byte_t nr50, nr51, nr52;
  logic  wr_nr52;
  logic  power_off_wr;
  logic  wr_ok;

  assign power_on     = nr52[7];
  assign wr_nr52      = bus.write && (bus.addr == addr_nr52);
  assign power_off_wr = wr_nr52 && !bus.data[7];
  // everything but NR52 is locked while powered down
  assign wr_ok        = bus.write && power_on && !wr_nr52;

  // ---------------------------------------------------------------------
  // write side
  always_ff @(posedge clk) begin
    if (rst || power_off_wr) begin
      nr11 <= rst_nr11;
      nr12 <= rst_nr12;
      nr13 <= rst_nr13;
      nr14 <= rst_nr14;
      nr21 <= rst_nr21;
      nr22 <= rst_nr22;
      nr23 <= rst_nr23;
      nr24 <= rst_nr24;
      nr50 <= rst_nr50;
      nr51 <= rst_nr51;
    end else if (wr_ok) begin
      case (bus.addr)
        addr_nr11: nr11 <= bus.data;
        addr_nr12: nr12 <= bus.data;
        addr_nr13: nr13 <= bus.data;
        addr_nr14: nr14 <= bus.data | wr_mask_nr14;
        addr_nr21: nr21 <= bus.data;
        addr_nr22: nr22 <= bus.data;
        addr_nr23: nr23 <= bus.data;
        addr_nr24: nr24 <= bus.data | wr_mask_nr24;
        addr_nr50: nr50 <= bus.data;
        addr_nr51: nr51 <= bus.data;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      nr52      <= rst_nr52;
      trig1     <= 1'b0;
      trig2     <= 1'b0;
      power_clr <= 1'b0;
    end else begin
      if (wr_nr52) begin
        nr52 <= bus.data | wr_mask_nr52;
      end
      trig1     <= wr_ok && (bus.addr == addr_nr14) && bus.data[7];
      trig2     <= wr_ok && (bus.addr == addr_nr24) && bus.data[7];
      power_clr <= power_off_wr;
    end
  end

  // ---------------------------------------------------------------------
  // read side, one cycle behind the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_out <= '0;
      bus_oe  <= 1'b0;
    end else begin
      bus_out <= '0;
      bus_oe  <= bus.read;
      if (bus.read) begin
        case (bus.addr)
          addr_nr10: bus_out <= rd_mask_nr10;
          addr_nr11: bus_out <= nr11 | rd_mask_nr11;
          addr_nr12: bus_out <= nr12 | rd_mask_nr12;
          addr_nr13: bus_out <= nr13 | rd_mask_nr13;
          addr_nr14: bus_out <= nr14 | rd_mask_nr14;
          addr_nr20: bus_out <= rd_mask_nr20;
          addr_nr21: bus_out <= nr21 | rd_mask_nr21;
          addr_nr22: bus_out <= nr22 | rd_mask_nr22;
          addr_nr23: bus_out <= nr23 | rd_mask_nr23;
          addr_nr24: bus_out <= nr24 | rd_mask_nr24;
          addr_nr50: bus_out <= nr50 | rd_mask_nr50;
          addr_nr51: bus_out <= nr51 | rd_mask_nr51;
          addr_nr52: bus_out <= (nr52 & 8'h80) | wr_mask_nr52 | {6'b0, en2, en1};
          default: bus_oe <= 1'b0;
        endcase
      end
    end
  end

  // ---------------------------------------------------------------------
  // field extraction
  always_comb begin
    cfg1.duty        = nr11[7:6];
    cfg1.length_load = nr11[5:0];
    cfg1.length_en   = nr14[6];
    cfg1.env_start   = nr12[7:4];
    cfg1.env_dir     = nr12[3];
    cfg1.env_period  = nr12[2:0];
    cfg1.freq        = {nr14[2:0], nr13};

    cfg2.duty        = nr21[7:6];
    cfg2.length_load = nr21[5:0];
    cfg2.length_en   = nr24[6];
    cfg2.env_start   = nr22[7:4];
    cfg2.env_dir     = nr22[3];
    cfg2.env_period  = nr22[2:0];
    cfg2.freq        = {nr24[2:0], nr23};

    mix.pan   = nr51;
    mix.vol_l = nr50[6:4];
    mix.vol_r = nr50[2:0];
  end

  // a trigger can only come out of an accepted write
  trig_needs_power: assert property (@(posedge clk) disable iff (rst) trig1 |-> power_on);

endmodule

`default_nettype wire

// ==== rtl/apu_voice_pkg.sv ====
`default_nettype none

package apu_voice_pkg;

  typedef logic [3:0]  sample_t;
  typedef logic [10:0] freq_t;
  typedef logic [3:0]  vol_t;
  typedef logic [6:0]  len_t;
  typedef logic [8:0]  out_t;

  // per-voice fields pulled out of the NRx1..NRx4 registers
  typedef struct packed {
    logic [1:0] duty;
    logic [5:0] length_load;
    logic       length_en;
    vol_t       env_start;
    logic       env_dir;
    logic [2:0] env_period;
    freq_t      freq;
  } pulse_cfg_t;

  typedef struct packed {
    logic step;
    logic length;
    logic env;
  } seq_ticks_t;

  typedef struct packed {
    logic [7:0] pan;
    logic [2:0] vol_l;
    logic [2:0] vol_r;
  } mix_cfg_t;

  localparam freq_t      freq_max   = 11'd2047;
  localparam vol_t       vol_max    = 4'd15;
  localparam len_t       len_full   = 7'd64;
  localparam logic [1:0] step_phase = 2'd2;

endpackage

`default_nettype wire

// ==== rtl/apu_reg_pkg.sv ====
`default_nettype none

package apu_reg_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;

  // one cpu access per cycle
  typedef struct packed {
    addr_t addr;
    byte_t data;
    logic  read;
    logic  write;
  } bus_req_t;

  // ---------------------------------------------------------------------
  // register map
  localparam addr_t addr_nr10 = 16'hFF10;
  localparam addr_t addr_nr11 = 16'hFF11;
  localparam addr_t addr_nr12 = 16'hFF12;
  localparam addr_t addr_nr13 = 16'hFF13;
  localparam addr_t addr_nr14 = 16'hFF14;
  localparam addr_t addr_nr20 = 16'hFF15;
  localparam addr_t addr_nr21 = 16'hFF16;
  localparam addr_t addr_nr22 = 16'hFF17;
  localparam addr_t addr_nr23 = 16'hFF18;
  localparam addr_t addr_nr24 = 16'hFF19;
  localparam addr_t addr_nr50 = 16'hFF24;
  localparam addr_t addr_nr51 = 16'hFF25;
  localparam addr_t addr_nr52 = 16'hFF26;

  // bits that always read as 1
  localparam byte_t rd_mask_nr10 = 8'hFF;
  localparam byte_t rd_mask_nr11 = 8'h3F;
  localparam byte_t rd_mask_nr12 = 8'h00;
  localparam byte_t rd_mask_nr13 = 8'hFF;
  localparam byte_t rd_mask_nr14 = 8'hBF;
  localparam byte_t rd_mask_nr20 = 8'hFF;
  localparam byte_t rd_mask_nr21 = 8'h3F;
  localparam byte_t rd_mask_nr22 = 8'h00;
  localparam byte_t rd_mask_nr23 = 8'hFF;
  localparam byte_t rd_mask_nr24 = 8'hBF;
  localparam byte_t rd_mask_nr50 = 8'h00;
  localparam byte_t rd_mask_nr51 = 8'h00;

  localparam byte_t wr_mask_nr14 = 8'h38;
  localparam byte_t wr_mask_nr24 = 8'h38;
  localparam byte_t wr_mask_nr52 = 8'h70;

  // power-up contents
  localparam byte_t rst_nr11 = 8'hBF;
  localparam byte_t rst_nr12 = 8'hF3;
  localparam byte_t rst_nr13 = 8'hFF;
  localparam byte_t rst_nr14 = 8'hBF;
  localparam byte_t rst_nr21 = 8'h3F;
  localparam byte_t rst_nr22 = 8'h00;
  localparam byte_t rst_nr23 = 8'hFF;
  localparam byte_t rst_nr24 = 8'hBF;
  localparam byte_t rst_nr50 = 8'h77;
  localparam byte_t rst_nr51 = 8'hF3;
  localparam byte_t rst_nr52 = 8'hF1;

endpackage

`default_nettype wire
